//--- verilog/pixelPkg.sv
`default_nettype none

package pixelPkg;

  // RGB565 field widths
  localparam int unsigned redBits = 5;
  localparam int unsigned greenBits = 6;
  localparam int unsigned blueBits = 5;

  // each field is widened to a full byte before weighting
  localparam int unsigned colourBits = 8;

  typedef struct packed {
    logic [redBits-1:0]   red;
    logic [greenBits-1:0] green;
    logic [blueBits-1:0]  blue;
  } rgb565Pixel;

  // luma weights in 1/256 units, they add up to exactly 256
  localparam logic [colourBits-1:0] redWeight = 8'd54;
  localparam logic [colourBits-1:0] greenWeight = 8'd183;
  localparam logic [colourBits-1:0] blueWeight = 8'd19;

  localparam int unsigned productBits = 16;
  localparam int unsigned grayShift = 8;

endpackage

`default_nettype wire

//--- verilog/ciPkg.sv
`default_nettype none

package ciPkg;

  localparam int unsigned wordBits = 32;
  localparam int unsigned ciNumberBits = 8;

  // custom instruction numbers as seen on ciN
  localparam logic [ciNumberBits-1:0] swapByteId = 8'd1;
  localparam logic [ciNumberBits-1:0] grayscaleId = 8'd9;

  // top bit of this counter releases the core
  localparam int unsigned resetCountBits = 5;

  // pixel sits in the low half, upper half is ignored
  typedef struct packed {
    logic [wordBits-$bits(pixelPkg::rgb565Pixel)-1:0] upper;
    pixelPkg::rgb565Pixel                             pixel;
  } pixelWord;

  typedef union packed {
    logic [wordBits/8-1:0][7:0] asBytes;
    pixelWord                   asPixel;
  } operandWord;

endpackage

`default_nettype wire

//--- verilog/captureIf.sv
`timescale 1ns/1ps
`default_nettype none

interface captureIf;

  logic              valid;
  logic              selSwap;
  logic              selGray;
  ciPkg::operandWord operand;

  modport producer (
    output valid,
    output selSwap,
    output selGray,
    output operand
  );

  modport consumer (
    input valid,
    input selSwap,
    input selGray,
    input operand
  );

endinterface

`default_nettype wire

//--- verilog/executeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface executeIf;

  logic                            valid;
  logic                            isGray;
  logic [ciPkg::wordBits-1:0]      swapWord;
  logic [pixelPkg::productBits-1:0] redProduct;
  logic [pixelPkg::productBits-1:0] greenProduct;
  logic [pixelPkg::productBits-1:0] blueProduct;

  modport producer (
    output valid,
    output isGray,
    output swapWord,
    output redProduct,
    output greenProduct,
    output blueProduct
  );

  modport consumer (
    input valid,
    input isGray,
    input swapWord,
    input redProduct,
    input greenProduct,
    input blueProduct
  );

endinterface

`default_nettype wire

//--- verilog/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReady
);

  logic [ciPkg::resetCountBits-1:0] resetCount;

  // counts up after lock, freezes once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[ciPkg::resetCountBits-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  // high from the 16th edge after lock
  assign coreReady = resetCount[ciPkg::resetCountBits-1];

endmodule

`default_nettype wire

//--- verilog/ciCapture.sv
`timescale 1ns/1ps
`default_nettype none

module ciCapture (
  input  logic                           s_systemClock,
  input  logic                           s_pllLocked,
  input  logic                           coreReady,
  input  logic                           ciStart,
  input  logic [ciPkg::ciNumberBits-1:0] ciN,
  input  ciPkg::operandWord              ciDataA,
  captureIf.producer                     stage
);

  logic isSwap;
  logic isGray;
  logic accept;

  // the only place where ciN gets decoded
  assign isSwap = (ciN == ciPkg::swapByteId);
  assign isGray = (ciN == ciPkg::grayscaleId);

  // unclaimed numbers or a core still in reset never enter the pipe
  assign accept = ciStart & coreReady & (isSwap | isGray);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stage.valid   <= 1'b0;
      stage.selSwap <= 1'b0;
      stage.selGray <= 1'b0;
      stage.operand <= '0;
    end else begin
      stage.valid   <= accept;
      stage.selSwap <= accept & isSwap;
      stage.selGray <= accept & isGray;
      stage.operand <= ciDataA;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ciExecute.sv
`timescale 1ns/1ps
`default_nettype none

module ciExecute (
  input  logic       s_systemClock,
  input  logic       s_pllLocked,
  captureIf.consumer capture,
  executeIf.producer stage
);

  localparam int unsigned redPad = pixelPkg::colourBits - pixelPkg::redBits;
  localparam int unsigned greenPad = pixelPkg::colourBits - pixelPkg::greenBits;
  localparam int unsigned bluePad = pixelPkg::colourBits - pixelPkg::blueBits;

  pixelPkg::rgb565Pixel             pixel;
  logic [pixelPkg::colourBits-1:0]  redWide;
  logic [pixelPkg::colourBits-1:0]  greenWide;
  logic [pixelPkg::colourBits-1:0]  blueWide;
  logic [ciPkg::wordBits-1:0]       swapped;

  assign pixel = capture.operand.asPixel.pixel;

  // widen by repeating the top bits, so full scale maps to 255
  assign redWide = {pixel.red, pixel.red[pixelPkg::redBits-1 -: redPad]};
  assign greenWide = {pixel.green, pixel.green[pixelPkg::greenBits-1 -: greenPad]};
  assign blueWide = {pixel.blue, pixel.blue[pixelPkg::blueBits-1 -: bluePad]};

  // byte 3 ends up in byte 0 and so on
  assign swapped = {capture.operand.asBytes[0], capture.operand.asBytes[1],
                    capture.operand.asBytes[2], capture.operand.asBytes[3]};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stage.valid        <= 1'b0;
      stage.isGray       <= 1'b0;
      stage.swapWord     <= '0;
      stage.redProduct   <= '0;
      stage.greenProduct <= '0;
      stage.blueProduct  <= '0;
    end else begin
      stage.valid  <= capture.valid;
      stage.isGray <= capture.selGray;
      // unselected unit contributes zero to the OR in writeback
      stage.swapWord <= capture.selSwap ? swapped : '0;
      if (capture.selGray) begin
        stage.redProduct   <= redWide * pixelPkg::redWeight;
        stage.greenProduct <= greenWide * pixelPkg::greenWeight;
        stage.blueProduct  <= blueWide * pixelPkg::blueWeight;
      end else begin
        stage.redProduct   <= '0;
        stage.greenProduct <= '0;
        stage.blueProduct  <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ciWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module ciWriteback (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  executeIf.consumer        execute,
  output logic              ciDone,
  output ciPkg::operandWord ciResult
);

  logic [pixelPkg::productBits-1:0] graySum;
  logic [ciPkg::wordBits-1:0]       grayWord;

  // weights total 256, so the sum stays within 16 bits
  assign graySum = execute.redProduct + execute.greenProduct + execute.blueProduct;

  always_comb begin
    grayWord = '0;
    if (execute.isGray) begin
      grayWord = {{(ciPkg::wordBits - pixelPkg::productBits){1'b0}},
                  graySum >> pixelPkg::grayShift};
    end
  end

  // wired-OR merge of both units
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= execute.valid;
      ciResult <= grayWord | execute.swapWord;
    end
  end

endmodule

`default_nettype wire

//--- verilog/or1420CiCore.sv
`timescale 1ns/1ps
`default_nettype none

module or1420CiCore (
  input  logic                           s_systemClock,
  input  logic                           s_pllLocked,
  input  logic                           ciStart,
  input  logic [ciPkg::ciNumberBits-1:0] ciN,
  input  logic [ciPkg::wordBits-1:0]     ciDataA,
  output logic                           ciDone,
  output logic [ciPkg::wordBits-1:0]     ciResult,
  output logic                           coreReady
);

  captureIf captureBus ();
  executeIf executeBus ();

  resetSequencer resetSeq (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .coreReady     (coreReady)
  );

  // stage 1, sample and decode
  ciCapture capture (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .coreReady     (coreReady),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .stage         (captureBus.producer)
  );

  // stage 2, swap and weight
  ciExecute execute (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .capture       (captureBus.consumer),
    .stage         (executeBus.producer)
  );

  // stage 3, merge and drive the CPU side
  ciWriteback writeback (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .execute       (executeBus.consumer),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

`default_nettype wire

//--- bench/ciVectorsTb.svh
`ifndef ciVectorsTbSvh
`define ciVectorsTbSvh

// columns: ciN, operand, expected ciResult, done expected
localparam int vectorCount = 18;

logic [7:0]  vecN [vectorCount];
logic [31:0] vecData [vectorCount];
logic [31:0] vecExpect [vectorCount];
bit          vecHasDone [vectorCount];
int          vectorFill = 0;

task automatic addVector(input logic [7:0] number, input logic [31:0] operand,
                         input logic [31:0] expected, input bit hasDone);
  vecN[vectorFill] = number;
  vecData[vectorFill] = operand;
  vecExpect[vectorFill] = expected;
  vecHasDone[vectorFill] = hasDone;
  vectorFill++;
endtask

task automatic loadVectors();
  vectorFill = 0;
  addVector(8'd1, 32'h1234_5678, 32'h7856_3412, 1'b1);
  // white and black
  addVector(8'd9, 32'h0000_FFFF, 32'h0000_00FF, 1'b1);
  addVector(8'd9, 32'h0000_0000, 32'h0000_0000, 1'b1);
  addVector(8'd0, 32'h1234_5678, 32'h0000_0000, 1'b0);
  addVector(8'd1, 32'hDEAD_BEEF, 32'hEFBE_ADDE, 1'b1);
  // pure red, green, blue
  addVector(8'd9, 32'h0000_F800, 32'h0000_0035, 1'b1);
  addVector(8'd9, 32'h0000_07E0, 32'h0000_00B6, 1'b1);
  addVector(8'd9, 32'h0000_001F, 32'h0000_0012, 1'b1);
  addVector(8'd2, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
  addVector(8'd1, 32'h0000_0000, 32'h0000_0000, 1'b1);
  // upper half must not leak into the gray value
  addVector(8'd9, 32'hDEAD_FFFF, 32'h0000_00FF, 1'b1);
  addVector(8'd9, 32'h1234_8410, 32'h0000_0082, 1'b1);
  addVector(8'd8, 32'h0000_FFFF, 32'h0000_0000, 1'b0);
  addVector(8'd1, 32'hFF00_0001, 32'h0100_00FF, 1'b1);
  addVector(8'd9, 32'h0000_F81F, 32'h0000_0048, 1'b1);
  addVector(8'd9, 32'h0000_07FF, 32'h0000_00C9, 1'b1);
  addVector(8'd255, 32'hA5C3_0F81, 32'h0000_0000, 1'b0);
  addVector(8'd1, 32'hA5C3_0F81, 32'h810F_C3A5, 1'b1);
endtask

`endif

//--- bench/or1420CiCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module or1420CiCoreTb;

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        ciStart;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic        ciDone;
  logic [31:0] ciResult;
  logic        coreReady;

  `include "ciVectorsTb.svh"

  localparam int randomCount = 24;
  // table runs twice, spaced and back to back, then the random run
  localparam int cycleLimit = 40 + 4 * (2 * vectorCount + randomCount);

  int          cycleCount = 0;
  int          tagQueue[$];
  int          dueQueue[$];
  logic [31:0] resultQueue[$];
  int          doneTag;
  int          doneDue;
  logic [31:0] doneExpect;

  or1420CiCore dut (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .coreReady     (coreReady)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #2 s_systemClock = ~s_systemClock;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s expected %h actual %h", testName, expected, actual));
    end
  endtask

  function automatic logic [31:0] reverseBytes(input logic [31:0] word);
    logic [31:0] result;
    int          i;
    for (i = 0; i < 4; i++) begin
      result[8*i +: 8] = word[8*(3-i) +: 8];
    end
    return result;
  endfunction

  // widen 5/6 bit fields by copying their top bits, then weight and scale by 1/256
  function automatic logic [31:0] grayLevel(input logic [31:0] word);
    int red;
    int green;
    int blue;
    red = (word >> 11) & 31;
    green = (word >> 5) & 63;
    blue = word & 31;
    red = (red << 3) | (red >> 2);
    green = (green << 2) | (green >> 4);
    blue = (blue << 3) | (blue >> 2);
    return (red * 54 + green * 183 + blue * 19) / 256;
  endfunction

  function automatic string vectorName(input int tag);
    if (tag < vectorCount) begin
      return $sformatf("table vector %0d", tag);
    end
    return $sformatf("random vector %0d", tag - vectorCount);
  endfunction

  task automatic issue(input logic [7:0] number, input logic [31:0] operand,
                       input logic [31:0] expected, input bit hasDone, input int tag);
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN <= number;
    ciDataA <= operand;
    // sampled on the next edge, done seen three edges later
    if (hasDone) begin
      tagQueue.push_back(tag);
      resultQueue.push_back(expected);
      dueQueue.push_back(cycleCount + 4);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge s_systemClock);
      ciStart <= 1'b0;
    end
  endtask

  // scoreboard and cycle limit
  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      failRun($sformatf("run did not finish within %0d cycles", cycleLimit));
    end
    if (dueQueue.size() != 0 && dueQueue[0] < cycleCount) begin
      failRun($sformatf("no ciDone arrived for %s", vectorName(tagQueue[0])));
    end
    if (ciDone === 1'b1) begin
      if (tagQueue.size() == 0) begin
        failRun("ciDone pulsed with no instruction outstanding");
      end
      doneTag = tagQueue.pop_front();
      doneExpect = resultQueue.pop_front();
      doneDue = dueQueue.pop_front();
      checkValue($sformatf("%s done cycle", vectorName(doneTag)), doneDue, cycleCount);
      checkValue(vectorName(doneTag), doneExpect, ciResult);
    end else begin
      checkValue("ciResult outside done", 32'h0, ciResult);
    end
  end

  initial begin
    int          i;
    logic [7:0]  number;
    logic [31:0] operand;
    logic [31:0] expected;
    void'($urandom(59));
    s_pllLocked <= 1'b0;
    ciStart <= 1'b0;
    ciN <= 8'd0;
    ciDataA <= 32'h0;
    loadVectors();

    // starts during reset must be dropped
    repeat (5) begin
      @(posedge s_systemClock);
      checkValue("coreReady in reset", 32'h0, coreReady);
      ciStart <= 1'b1;
      ciN <= 8'd1;
      ciDataA <= 32'h0102_0304;
    end
    s_pllLocked <= 1'b1;
    for (i = 0; i < 16; i++) begin
      @(posedge s_systemClock);
      checkValue("coreReady before release", 32'h0, coreReady);
      if (i >= 14) begin
        ciStart <= 1'b0;
      end
    end
    @(posedge s_systemClock);
    checkValue("coreReady after 16 edges", 32'h1, coreReady);

    // one instruction at a time
    for (i = 0; i < vectorCount; i++) begin
      issue(vecN[i], vecData[i], vecExpect[i], vecHasDone[i], i);
      idle(4);
    end

    // whole table back to back
    for (i = 0; i < vectorCount; i++) begin
      issue(vecN[i], vecData[i], vecExpect[i], vecHasDone[i], i);
    end

    for (i = 0; i < randomCount; i++) begin
      number = ($urandom % 2) ? 8'd1 : 8'd9;
      operand = $urandom;
      expected = (number == 8'd1) ? reverseBytes(operand) : grayLevel(operand);
      issue(number, operand, expected, 1'b1, vectorCount + i);
    end
    idle(1);

    while (tagQueue.size() != 0) begin
      @(posedge s_systemClock);
    end
    idle(4);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- or1420CiCore.f
+incdir+bench
verilog/pixelPkg.sv
verilog/ciPkg.sv
verilog/captureIf.sv
verilog/executeIf.sv
verilog/resetSequencer.sv
verilog/ciCapture.sv
verilog/ciExecute.sv
verilog/ciWriteback.sv
verilog/or1420CiCore.sv
bench/or1420CiCoreTb.sv

//--- Bender.yml
package:
  name: or1420CiCore

sources:
  # packages first, pixelPkg is used by ciPkg
  - files:
      - verilog/pixelPkg.sv
      - verilog/ciPkg.sv
      - verilog/captureIf.sv
      - verilog/executeIf.sv
      - verilog/resetSequencer.sv
      - verilog/ciCapture.sv
      - verilog/ciExecute.sv
      - verilog/ciWriteback.sv
      - verilog/or1420CiCore.sv

  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/or1420CiCoreTb.sv
